//--- logic/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOp_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_WORD, MEM_BYTE, MEM_BYTEU
    } memSize_e;

    typedef enum logic [1:0] {
        FWD_REG, FWD_FROM_MEM, FWD_FROM_WB
    } fwdSel_e;

    typedef struct packed {
        aluOp_e                  aluOp;
        logic                    useImm;    // srcB is the immediate
        logic                    regWrite;
        logic [`REG_ADDR_W-1:0] writeReg;
        logic                    memRead;
        logic                    memWrite;
        memSize_e                memSize;
        logic                    isBranch;
        logic                    branchNe;  // bne, else beq
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`XLEN-1:0]       rd1;
        logic [`XLEN-1:0]       rd2;
        logic [`XLEN-1:0]       imm;
        logic [4:0]             sa;
        ctrl_t                  ctrl;
        logic                   valid;
    } decExe_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] aluOut;
        logic [`XLEN-1:0] storeData;
        ctrl_t            ctrl;
        logic             valid;
    } exeMem_t;

endpackage

//--- logic/cpuTop.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuTop import cpuPkg::*; (
    input  logic                   clk_i,
    input  logic                   rstN_i,
    output logic [`XLEN-1:0]       instAddr_o,
    output logic                   instEn_o,
    input  logic [`XLEN-1:0]       instr_i,
    output logic                   memEn_o,
    output logic [`XLEN-1:0]       memAddr_o,
    output logic [3:0]             memWen_o,
    output logic [`XLEN-1:0]       memWdata_o,
    input  logic [`XLEN-1:0]       memRdata_i,
    input  logic                   dStall_i,
    output logic [`XLEN-1:0]       debugWbPc_o,
    output logic [3:0]             debugWbRfWen_o,
    output logic [`REG_ADDR_W-1:0] debugWbRfWnum_o,
    output logic [`XLEN-1:0]       debugWbRfWdata_o
);

    hazardIf hz ();

    logic [`XLEN-1:0]       pcD, instrD, rd1, rd2;
    logic [`XLEN-1:0]       branchTarget, jumpTarget;
    logic [`XLEN-1:0]       resultM, resultW, rfWdata;
    logic [`REG_ADDR_W-1:0] rsAddr, rtAddr, rfWaddr;
    logic                   rfWen;
    decExe_t                decExe;
    exeMem_t                exeMem;

    fetchStage u_fetchStage (
        .clk_i, .rstN_i, .hz_i(hz.fetch),
        .branchTarget_i(branchTarget), .jumpTarget_i(jumpTarget), .instr_i,
        .instAddr_o, .instEn_o, .pcD_o(pcD), .instrD_o(instrD)
    );

    decodeStage u_decodeStage (
        .clk_i, .rstN_i, .hz_i(hz.decode),
        .pcD_i(pcD), .instrD_i(instrD), .rd1_i(rd1), .rd2_i(rd2),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr), .jumpTarget_o(jumpTarget), .decExe_o(decExe)
    );

    regFile u_regFile (
        .clk_i, .rstN_i, .rsAddr_i(rsAddr), .rtAddr_i(rtAddr),
        .wen_i(rfWen), .waddr_i(rfWaddr), .wdata_i(rfWdata), .rd1_o(rd1), .rd2_o(rd2)
    );

    executeStage u_executeStage (
        .clk_i, .rstN_i, .hz_i(hz.execute), .decExe_i(decExe),
        .resultM_i(resultM), .resultW_i(resultW),
        .branchTarget_o(branchTarget), .exeMem_o(exeMem)
    );

    memStage u_memStage (
        .clk_i, .rstN_i, .hz_i(hz.memory), .exeMem_i(exeMem), .memRdata_i,
        .memEn_o, .memAddr_o, .memWen_o, .memWdata_o,
        .resultM_o(resultM), .resultW_o(resultW),
        .rfWen_o(rfWen), .rfWaddr_o(rfWaddr), .rfWdata_o(rfWdata),
        .debugWbPc_o, .debugWbRfWen_o, .debugWbRfWnum_o, .debugWbRfWdata_o
    );

    hazardUnit u_hazardUnit (.hz_i(hz.hazard), .dStall_i);

endmodule

//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// data and address width
`define XLEN 32

// general register file size
`define REG_COUNT 32
`define REG_ADDR_W 5

// sequential fetch increment
`define LINK_PC_STEP 32'd4

`endif

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decodeStage import cpuPkg::*; (
    input  logic                    clk_i,
    input  logic                    rstN_i,
    hazardIf.decode                 hz_i,
    input  logic [`XLEN-1:0]        pcD_i,
    input  logic [`XLEN-1:0]        instrD_i,
    input  logic [`XLEN-1:0]        rd1_i,
    input  logic [`XLEN-1:0]        rd2_i,
    output logic [`REG_ADDR_W-1:0]  rsAddr_o,
    output logic [`REG_ADDR_W-1:0]  rtAddr_o,
    output logic [`XLEN-1:0]        jumpTarget_o,
    output decExe_t                 decExe_o
);

    opcode_e                opcode;
    funct_e                 funct;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       pcPlus;
    ctrl_t                  ctrl;

    assign opcode   = opcode_e'(instrD_i[31:26]);
    assign funct    = funct_e'(instrD_i[5:0]);
    assign rsAddr_o = instrD_i[25:21];
    assign rtAddr_o = instrD_i[20:16];
    assign rd       = instrD_i[15:11];

    // ori takes a zero-extended immediate
    assign imm = (opcode == OP_ORI) ? {16'b0, instrD_i[15:0]}
                                    : {{16{instrD_i[15]}}, instrD_i[15:0]};

    assign pcPlus       = pcD_i + `LINK_PC_STEP;
    assign jumpTarget_o = {pcPlus[31:28], instrD_i[25:0], 2'b00};
    assign hz_i.jumpD   = (opcode == OP_J);

    always_comb begin
        ctrl = '{aluOp: ALU_ADD, memSize: MEM_NONE, default: '0};
        case (opcode)
            OP_SPECIAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.writeReg = rd;
                case (funct)
                    FN_SLL:  ctrl.aluOp = ALU_SLL;
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    default: ctrl.regWrite = 1'b0;  // unknown funct is a nop
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW, OP_LB, OP_LBU: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeReg = rtAddr_o;
                if (opcode == OP_ORI) ctrl.aluOp = ALU_OR;
                if (opcode == OP_LUI) ctrl.aluOp = ALU_LUI;
                ctrl.memRead = (opcode == OP_LW) || (opcode == OP_LB) || (opcode == OP_LBU);
                if (opcode == OP_LW)  ctrl.memSize = MEM_WORD;
                if (opcode == OP_LB)  ctrl.memSize = MEM_BYTE;
                if (opcode == OP_LBU) ctrl.memSize = MEM_BYTEU;
            end
            OP_SW, OP_SB: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.memSize  = (opcode == OP_SW) ? MEM_WORD : MEM_BYTE;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = (opcode == OP_BNE);
            end
            default: ;  // j and undefined opcodes write nothing
        endcase
        // writes to r0 never reach the trace
        if (ctrl.writeReg == '0) ctrl.regWrite = 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            decExe_o.valid <= 1'b0;
        end else if (!hz_i.stall) begin
            decExe_o.pc    <= pcD_i;
            decExe_o.rs    <= rsAddr_o;
            decExe_o.rt    <= rtAddr_o;
            decExe_o.rd1   <= rd1_i;
            decExe_o.rd2   <= rd2_i;
            decExe_o.imm   <= imm;
            decExe_o.sa    <= instrD_i[10:6];
            decExe_o.ctrl  <= ctrl;
            decExe_o.valid <= ~hz_i.flushE;  // squashed behind a taken branch
        end
    end

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module executeStage import cpuPkg::*; (
    input  logic              clk_i,
    input  logic              rstN_i,
    hazardIf.execute          hz_i,
    input  decExe_t           decExe_i,
    input  logic [`XLEN-1:0]  resultM_i,
    input  logic [`XLEN-1:0]  resultW_i,
    output logic [`XLEN-1:0]  branchTarget_o,
    output exeMem_t           exeMem_o
);

    logic [`XLEN-1:0] rsVal, rtVal, srcB, aluOut;
    logic             equal;

    assign hz_i.rsE = decExe_i.rs;
    assign hz_i.rtE = decExe_i.rt;

    always_comb begin
        case (hz_i.fwdSelA)
            FWD_FROM_MEM: rsVal = resultM_i;
            FWD_FROM_WB:  rsVal = resultW_i;
            default:      rsVal = decExe_i.rd1;
        endcase
        case (hz_i.fwdSelB)
            FWD_FROM_MEM: rtVal = resultM_i;
            FWD_FROM_WB:  rtVal = resultW_i;
            default:      rtVal = decExe_i.rd2;
        endcase
    end

    assign srcB = decExe_i.ctrl.useImm ? decExe_i.imm : rtVal;

    always_comb begin
        case (decExe_i.ctrl.aluOp)
            ALU_SUB: aluOut = rsVal - srcB;
            ALU_AND: aluOut = rsVal & srcB;
            ALU_OR:  aluOut = rsVal | srcB;
            ALU_XOR: aluOut = rsVal ^ srcB;
            ALU_SLT: aluOut = {31'b0, $signed(rsVal) < $signed(srcB)};
            ALU_SLL: aluOut = rtVal << decExe_i.sa;
            ALU_LUI: aluOut = {srcB[15:0], 16'b0};
            default: aluOut = rsVal + srcB;  // add and address calc
        endcase
    end

    // not taken by default, corrected here
    assign equal             = (rsVal == rtVal);
    assign hz_i.branchTakenE = decExe_i.valid && decExe_i.ctrl.isBranch &&
                               (equal ^ decExe_i.ctrl.branchNe);
    assign branchTarget_o    = decExe_i.pc + `LINK_PC_STEP + {decExe_i.imm[29:0], 2'b00};

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            exeMem_o.valid <= 1'b0;
        end else if (!hz_i.stall) begin
            exeMem_o.pc        <= decExe_i.pc;
            exeMem_o.aluOut    <= aluOut;
            exeMem_o.storeData <= rtVal;  // forwarded rt
            exeMem_o.ctrl      <= decExe_i.ctrl;
            exeMem_o.valid     <= decExe_i.valid;
        end
    end

endmodule

//--- logic/fetchStage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetchStage (
    input  logic              clk_i,
    input  logic              rstN_i,
    hazardIf.fetch            hz_i,
    input  logic [`XLEN-1:0]  branchTarget_i,
    input  logic [`XLEN-1:0]  jumpTarget_i,
    input  logic [`XLEN-1:0]  instr_i,
    output logic [`XLEN-1:0]  instAddr_o,
    output logic              instEn_o,
    output logic [`XLEN-1:0]  pcD_o,
    output logic [`XLEN-1:0]  instrD_o
);

    logic [`XLEN-1:0] pc;

    assign instAddr_o = pc;
    assign instEn_o   = ~hz_i.flushD;  // fetched word is dropped anyway

    // flushE only rises on a taken branch, flushD also on a jump
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            pc <= `RESET_PC;
        end else if (hz_i.flushE) begin
            pc <= branchTarget_i;
        end else if (hz_i.flushD) begin
            pc <= jumpTarget_i;
        end else if (!hz_i.stall) begin
            pc <= pc + `LINK_PC_STEP;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            pcD_o    <= `RESET_PC;
            instrD_o <= '0;
        end else if (hz_i.flushD) begin
            instrD_o <= '0;  // sll r0 as nop
        end else if (!hz_i.stall) begin
            pcD_o    <= pc;
            instrD_o <= instr_i;
        end
    end

endmodule

//--- logic/hazardIf.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

interface hazardIf import cpuPkg::*; ();

    logic [`REG_ADDR_W-1:0] rsE, rtE;
    logic                   branchTakenE;
    logic                   jumpD;
    logic                   regWriteM, regWriteW;
    logic [`REG_ADDR_W-1:0] writeRegM, writeRegW;
    logic                   stall;       // whole pipeline holds
    logic                   flushD, flushE;
    fwdSel_e                fwdSelA, fwdSelB;

    modport fetch (input stall, flushD, flushE);
    modport decode (output jumpD, input stall, flushE);
    modport execute (output rsE, rtE, branchTakenE, input stall, fwdSelA, fwdSelB);
    modport memory (output regWriteM, writeRegM, regWriteW, writeRegW, input stall);
    modport hazard (
        input  rsE, rtE, branchTakenE, jumpD, regWriteM, writeRegM, regWriteW, writeRegW,
        output stall, flushD, flushE, fwdSelA, fwdSelB
    );

endinterface

//--- logic/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
    hazardIf.hazard hz_i,
    input  logic    dStall_i
);

    assign hz_i.stall = dStall_i;

    // no flush while the pipeline is frozen
    assign hz_i.flushE = hz_i.branchTakenE & ~dStall_i;
    assign hz_i.flushD = (hz_i.branchTakenE | hz_i.jumpD) & ~dStall_i;

    // memory stage holds the younger result, so it wins
    always_comb begin
        hz_i.fwdSelA = FWD_REG;
        if (hz_i.rsE != '0) begin
            if (hz_i.regWriteM && hz_i.writeRegM == hz_i.rsE) begin
                hz_i.fwdSelA = FWD_FROM_MEM;
            end else if (hz_i.regWriteW && hz_i.writeRegW == hz_i.rsE) begin
                hz_i.fwdSelA = FWD_FROM_WB;
            end
        end
    end

    always_comb begin
        hz_i.fwdSelB = FWD_REG;
        if (hz_i.rtE != '0) begin
            if (hz_i.regWriteM && hz_i.writeRegM == hz_i.rtE) begin
                hz_i.fwdSelB = FWD_FROM_MEM;
            end else if (hz_i.regWriteW && hz_i.writeRegW == hz_i.rtE) begin
                hz_i.fwdSelB = FWD_FROM_WB;
            end
        end
    end

endmodule

//--- logic/memStage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module memStage import cpuPkg::*; (
    input  logic                   clk_i,
    input  logic                   rstN_i,
    hazardIf.memory                hz_i,
    input  exeMem_t                exeMem_i,
    input  logic [`XLEN-1:0]       memRdata_i,
    output logic                   memEn_o,
    output logic [`XLEN-1:0]       memAddr_o,
    output logic [3:0]             memWen_o,
    output logic [`XLEN-1:0]       memWdata_o,
    output logic [`XLEN-1:0]       resultM_o,
    output logic [`XLEN-1:0]       resultW_o,
    output logic                   rfWen_o,
    output logic [`REG_ADDR_W-1:0] rfWaddr_o,
    output logic [`XLEN-1:0]       rfWdata_o,
    output logic [`XLEN-1:0]       debugWbPc_o,
    output logic [3:0]             debugWbRfWen_o,
    output logic [`REG_ADDR_W-1:0] debugWbRfWnum_o,
    output logic [`XLEN-1:0]       debugWbRfWdata_o
);

    logic       store;
    logic [1:0] lane;
    logic [7:0] loadByte;
    logic [`XLEN-1:0] loadData;

    assign lane  = exeMem_i.aluOut[1:0];
    assign store = exeMem_i.valid & exeMem_i.ctrl.memWrite;

    assign memEn_o    = exeMem_i.valid & (exeMem_i.ctrl.memRead | exeMem_i.ctrl.memWrite);
    assign memAddr_o  = exeMem_i.aluOut;
    assign memWen_o   = !store ? 4'b0000 :
                        (exeMem_i.ctrl.memSize == MEM_BYTE) ? 4'b0001 << lane : 4'b1111;
    assign memWdata_o = (exeMem_i.ctrl.memSize == MEM_BYTE) ? {4{exeMem_i.storeData[7:0]}}
                                                            : exeMem_i.storeData;

    assign loadByte = memRdata_i[lane*8 +: 8];

    always_comb begin
        case (exeMem_i.ctrl.memSize)
            MEM_BYTE:  loadData = {{24{loadByte[7]}}, loadByte};
            MEM_BYTEU: loadData = {24'b0, loadByte};
            default:   loadData = memRdata_i;
        endcase
    end

    assign resultM_o      = exeMem_i.ctrl.memRead ? loadData : exeMem_i.aluOut;
    assign hz_i.regWriteM = exeMem_i.valid & exeMem_i.ctrl.regWrite;
    assign hz_i.writeRegM = exeMem_i.ctrl.writeReg;

    // trace reports each write once, on the cycle it leaves memory
    assign debugWbPc_o      = exeMem_i.pc;
    assign debugWbRfWen_o   = {4{hz_i.regWriteM & ~hz_i.stall}};
    assign debugWbRfWnum_o  = exeMem_i.ctrl.writeReg;
    assign debugWbRfWdata_o = resultM_o;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            hz_i.regWriteW <= 1'b0;
        end else if (!hz_i.stall) begin
            hz_i.regWriteW <= hz_i.regWriteM;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hz_i.stall) begin
            hz_i.writeRegW <= hz_i.writeRegM;
            resultW_o      <= resultM_o;
        end
    end

    assign rfWen_o   = hz_i.regWriteW;
    assign rfWaddr_o = hz_i.writeRegW;
    assign rfWdata_o = resultW_o;

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile (
    input  logic                   clk_i,
    input  logic                   rstN_i,
    input  logic [`REG_ADDR_W-1:0] rsAddr_i,
    input  logic [`REG_ADDR_W-1:0] rtAddr_i,
    input  logic                   wen_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    output logic [`XLEN-1:0]       rd1_o,
    output logic [`XLEN-1:0]       rd2_o
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback in the same cycle bypasses the array
    always_comb begin
        rd1_o = regs[rsAddr_i];
        rd2_o = regs[rtAddr_i];
        if (wen_i && waddr_i == rsAddr_i) rd1_o = wdata_i;
        if (wen_i && waddr_i == rtAddr_i) rd2_o = wdata_i;
        if (rsAddr_i == '0) rd1_o = '0;
        if (rtAddr_i == '0) rd2_o = '0;
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the cpuTop testbench with Verilator
verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module tb_cpuTop \
    -o tb_cpuTop \
    && ./obj_dir/tb_cpuTop > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

//--- sim/tb_cpuTop.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpuTop;

    localparam int TEST_CYCLES = 2000;
    localparam int TEST_COUNT  = 5;
    localparam int MAX_STEPS   = 500;  // model instruction budget
    localparam int LOOP_HITS   = 6;    // fetches of the final loop before draining

    // MIPS encodings
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SW      = 6'h2b;
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    logic        clk;
    logic        rstN;
    logic [31:0] instAddr, instr, memAddr, memWdata, memRdata;
    logic        instEn, memEn, dStall;
    logic [3:0]  memWen, dbgWen;
    logic [31:0] dbgPc, dbgData;
    logic [4:0]  dbgNum;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] modelRam [256];
    logic [31:0] modelRegs [32];
    logic [68:0] expRegQ [$];  // pc, reg, data
    logic [67:0] expMemQ [$];  // addr, wen, wdata
    logic [68:0] prevPort;
    logic [32:0] prevFetch;    // enable, address
    logic [31:0] loopPc;
    logic        stallOn, monitorOn, prevStall;
    int          progLen, errors, checks, seed;

    cpuTop u_cpuTop (
        .clk_i(clk), .rstN_i(rstN),
        .instAddr_o(instAddr), .instEn_o(instEn), .instr_i(instr),
        .memEn_o(memEn), .memAddr_o(memAddr), .memWen_o(memWen), .memWdata_o(memWdata),
        .memRdata_i(memRdata), .dStall_i(dStall),
        .debugWbPc_o(dbgPc), .debugWbRfWen_o(dbgWen),
        .debugWbRfWnum_o(dbgNum), .debugWbRfWdata_o(dbgData)
    );

    // both memories answer in the same cycle
    assign instr    = instEn ? rom[instAddr[9:2]] : 32'h0;
    assign memRdata = ram[memAddr[9:2]];

    always #50 clk = ~clk;

    always @(negedge clk) begin
        dStall = stallOn && ($urandom_range(0, 99) < 30);  // about 30% busy
    end

    task logMismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    function automatic logic [31:0] encodeI(logic [5:0] op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] encodeR(logic [5:0] fn, int rs, int rt, int rd, int sa);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
    endfunction

    function automatic logic [31:0] encodeJ(logic [31:0] target);
        return {OP_J, target[27:2]};
    endfunction

    task emit(input logic [31:0] word);
        rom[progLen] = word;
        progLen++;
    endtask

    task finishProgram();
        loopPc = progLen * 4;
        emit(encodeJ(loopPc));  // self loop ends the program
    endtask

    task prepareMemories();
        for (int i = 0; i < 256; i++) begin
            rom[i]      = 32'h0;  // nop
            ram[i]      = 32'h9e37_79b1 * (i + 1);
            modelRam[i] = ram[i];
        end
        progLen = 0;
        expRegQ.delete();
        expMemQ.delete();
    endtask

    // reference ISS with no delay slots
    task automatic runModel();
        logic [31:0] pc, npc, ins, a, b, simm, addr, word, res;
        logic [7:0]  bval;
        logic [5:0]  op;
        logic [4:0]  dest;
        logic        wr, done;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'h0;
        end
        pc    = `RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < MAX_STEPS) begin
            ins  = rom[pc[9:2]];
            op   = ins[31:26];
            a    = modelRegs[ins[25:21]];
            b    = modelRegs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            word = modelRam[addr[9:2]];
            bval = word[8*addr[1:0] +: 8];
            dest = ins[20:16];
            wr   = 1'b1;
            res  = 32'h0;
            npc  = pc + 32'd4;
            case (op)
                OP_SPECIAL: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        FN_SLL:  res = b << ins[10:6];
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + simm;
                OP_ORI:   res = a | {16'h0, ins[15:0]};
                OP_LUI:   res = {ins[15:0], 16'h0};
                OP_LW:    res = word;
                OP_LB:    res = {{24{bval[7]}}, bval};
                OP_LBU:   res = {24'h0, bval};
                OP_SW: begin
                    wr = 1'b0;
                    modelRam[addr[9:2]] = b;
                    expMemQ.push_back({addr, 4'hf, b});
                end
                OP_SB: begin
                    wr = 1'b0;
                    modelRam[addr[9:2]][8*addr[1:0] +: 8] = b[7:0];
                    expMemQ.push_back({addr, 4'b0001 << addr[1:0], {4{b[7:0]}}});
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (op == OP_BEQ)) npc = pc + 32'd4 + {simm[29:0], 2'b00};
                end
                OP_J: begin
                    wr   = 1'b0;
                    npc  = {npc[31:28], ins[25:0], 2'b00};
                    done = (npc == pc);
                end
                default: wr = 1'b0;
            endcase
            if (op == OP_LW || op == OP_LB || op == OP_LBU) begin
                expMemQ.push_back({addr, 4'h0, 32'h0});  // loads enable no byte lanes
            end
            if (wr && dest != 5'd0) begin
                modelRegs[dest] = res;
                expRegQ.push_back({pc, dest, res});
            end
            pc = npc;
            steps++;
        end
        if (!done) begin
            errors++;
            $display("Golden model did not reach its final self-loop jump");
        end
    endtask

    task commitAccess();
        logic [67:0] entry;
        for (int b = 0; b < 4; b++) begin
            if (memWen[b]) ram[memAddr[9:2]][8*b +: 8] = memWdata[8*b +: 8];
        end
        checks++;
        if (expMemQ.size() == 0) begin
            errors++;
            $display("Unexpected data access at %0t ns to address %h", $time, memAddr);
        end else begin
            entry = expMemQ.pop_front();
            if (memEn !== 1'b1 || {memAddr, memWen} !== entry[67:32] ||
                (entry[35:32] != 4'h0 && memWdata !== entry[31:0])) begin
                logMismatch($sformatf("access en %b %h/%b/%h, expected %h/%b/%h", memEn,
                    memAddr, memWen, memWdata, entry[67:36], entry[35:32], entry[31:0]));
            end
        end
    endtask

    task checkRegWrite();
        logic [68:0] entry;
        checks++;
        if (expRegQ.size() == 0) begin
            errors++;
            $display("Unexpected register write at %0t ns from pc %h to r%0d", $time, dbgPc, dbgNum);
        end else begin
            entry = expRegQ.pop_front();
            if ({dbgPc, dbgNum, dbgData} !== entry || dbgWen !== 4'hf) begin
                logMismatch($sformatf("write pc %h r%0d=%h wen %b, expected pc %h r%0d=%h",
                    dbgPc, dbgNum, dbgData, dbgWen, entry[68:37], entry[36:32], entry[31:0]));
            end
        end
    endtask

    always @(posedge clk) begin
        if (monitorOn) begin
            if (dbgWen != 4'h0) checkRegWrite();
            if ((memEn || memWen != 4'h0) && !dStall) commitAccess();
            // a stalled access must hold until accepted
            if (prevStall && prevPort[68] && {memEn, memAddr, memWen, memWdata} !== prevPort) begin
                logMismatch($sformatf("data port changed while stalled, addr %h", memAddr));
            end
            // an enabled fetch that is not held moves on by one word
            if (!prevStall && prevFetch[32] && instAddr !== prevFetch[31:0] + 32'd4) begin
                logMismatch($sformatf("fetch went from %h to %h with instEn high",
                    prevFetch[31:0], instAddr));
            end
        end
        prevStall = dStall;
        prevPort  = {memEn, memAddr, memWen, memWdata};
        prevFetch = {instEn & rstN, instAddr};
    end

    task automatic resetDut();
        monitorOn = 1'b0;
        @(negedge clk);
        rstN = 1'b0;
        repeat (8) begin
            @(negedge clk);
            checks++;
            if (memEn !== 1'b0 || dbgWen !== 4'h0) logMismatch("port active during reset");
        end
        rstN = 1'b1;
        checks++;
        if (instAddr !== `RESET_PC || instEn !== 1'b1) begin
            logMismatch($sformatf("first fetch at %h en %b", instAddr, instEn));
        end
    endtask

    task automatic runProgram(input logic withStall);
        logic [68:0] regEntry;
        logic [67:0] memEntry;
        int          hits;
        int          cycles;
        hits   = 0;
        cycles = 0;
        runModel();
        resetDut();
        monitorOn = 1'b1;
        stallOn   = withStall;
        while (hits < LOOP_HITS && cycles < TEST_CYCLES) begin
            @(posedge clk);
            cycles++;
            if (!dStall && instAddr == loopPc) hits++;
        end
        stallOn = 1'b0;
        repeat (10) @(posedge clk);  // let older instructions drain
        monitorOn = 1'b0;
        if (hits < LOOP_HITS) begin
            errors++;
            $display("Program never settled in its final loop at %h", loopPc);
        end
        while (expRegQ.size() > 0) begin
            regEntry = expRegQ.pop_front();
            errors++;
            $display("Missing register write from pc %h to r%0d", regEntry[68:37], regEntry[36:32]);
        end
        while (expMemQ.size() > 0) begin
            memEntry = expMemQ.pop_front();
            errors++;
            $display("Missing data access to address %h", memEntry[67:36]);
        end
    endtask

    task testReset();
        prepareMemories();
        emit(encodeI(OP_ADDIU, 0, 1, 5));
        emit(encodeI(OP_ADDIU, 1, 2, 7));
        finishProgram();
        runProgram(1'b0);
    endtask

    task testAluForwarding();
        prepareMemories();
        emit(encodeI(OP_ADDIU, 0, 1, 'h1234));
        emit(encodeI(OP_ADDIU, 1, 2, -3));
        emit(encodeR(FN_ADDU, 1, 2, 3, 0));
        emit(encodeR(FN_SUBU, 3, 1, 4, 0));
        emit(encodeR(FN_AND, 4, 3, 5, 0));
        emit(encodeR(FN_OR, 5, 1, 6, 0));
        emit(encodeR(FN_XOR, 6, 2, 7, 0));
        emit(encodeR(FN_SLT, 7, 1, 8, 0));
        emit(encodeI(OP_ADDIU, 0, 9, -1));
        emit(encodeR(FN_SLT, 9, 0, 10, 0));  // signed compare
        emit(encodeR(FN_SLL, 0, 10, 11, 5));
        emit(encodeI(OP_ORI, 11, 12, 'h8001));  // zero extended
        emit(encodeI(OP_LUI, 0, 13, 'hbeef));
        emit(encodeR(FN_ADDU, 13, 12, 14, 0));
        emit(encodeI(OP_ADDIU, 14, 0, 1));  // r0 stays zero
        emit(encodeR(FN_ADDU, 0, 14, 15, 0));
        finishProgram();
        runProgram(1'b0);
    endtask

    task buildLoadStore();
        prepareMemories();
        emit(encodeI(OP_ADDIU, 0, 1, 'h100));
        emit(encodeI(OP_LUI, 0, 2, 'h8765));
        emit(encodeI(OP_ORI, 2, 2, 'h43a9));
        emit(encodeI(OP_SW, 1, 2, 0));
        emit(encodeI(OP_SB, 1, 2, 5));  // lane 1
        emit(encodeI(OP_ADDIU, 0, 3, 'h7f));
        emit(encodeI(OP_SB, 1, 3, 7));
        emit(encodeI(OP_LW, 1, 4, 0));
        emit(encodeI(OP_LB, 1, 5, 5));  // negative byte
        emit(encodeI(OP_LBU, 1, 6, 5));
        emit(encodeI(OP_LB, 1, 7, 7));
        emit(encodeI(OP_LW, 1, 8, 4));
        emit(encodeR(FN_ADDU, 8, 4, 9, 0));  // load-use
        emit(encodeI(OP_LBU, 1, 10, 2));
        emit(encodeI(OP_SW, 1, 10, 8));  // loaded value as store data
        emit(encodeI(OP_LW, 1, 11, 8));
        emit(encodeI(OP_SB, 1, 11, 11));
        emit(encodeI(OP_LW, 1, 12, 8));
        emit(encodeI(OP_LB, 0, 13, 'h202));
        finishProgram();
    endtask

    task testLoadStore();
        buildLoadStore();
        runProgram(1'b0);
    endtask

    task testControlFlow();
        prepareMemories();
        emit(encodeI(OP_ADDIU, 0, 1, 1));
        emit(encodeI(OP_ADDIU, 0, 2, 1));
        emit(encodeI(OP_BEQ, 1, 2, 2));  // taken to 5
        emit(encodeI(OP_ADDIU, 0, 3, 'h11));
        emit(encodeI(OP_ADDIU, 0, 4, 'h22));
        emit(encodeI(OP_ADDIU, 0, 5, 'h33));
        emit(encodeI(OP_BNE, 1, 2, 1));  // not taken
        emit(encodeI(OP_ADDIU, 0, 6, 'h44));
        emit(encodeI(OP_BNE, 5, 1, 1));  // taken to 10
        emit(encodeI(OP_SW, 0, 5, 0));
        emit(encodeJ(32'd48));
        emit(encodeI(OP_ADDIU, 0, 7, 'h55));
        emit(encodeI(OP_ADDIU, 5, 8, 1));
        emit(encodeI(OP_ADDIU, 0, 9, 3));
        emit(encodeI(OP_ADDIU, 9, 9, -1));
        emit(encodeI(OP_BNE, 9, 0, -2));  // back to 14
        emit(encodeI(OP_ADDIU, 0, 10, 'h66));
        finishProgram();
        runProgram(1'b0);
    endtask

    task testBackPressure();
        buildLoadStore();
        runProgram(1'b1);
    endtask

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        dStall    = 1'b0;
        stallOn   = 1'b0;
        monitorOn = 1'b0;
        prevStall = 1'b0;
        errors    = 0;
        checks    = 0;
        seed      = $urandom(13);
        testReset();
        testAluForwarding();
        testLoadStore();
        testControlFlow();
        testBackPressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TEST_COUNT * (TEST_CYCLES + 50) * 100);
        $display("Timeout: the run exceeded its cycle budget and was stopped");
        $display("Test failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/cpuPkg.sv
logic/hazardIf.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/regFile.sv
logic/executeStage.sv
logic/memStage.sv
logic/hazardUnit.sv
logic/cpuTop.sv
sim/tb_cpuTop.sv
